//--- design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DATA_W      32
`define CPU_ADDR_W      32
`define CPU_NUM_REGS    8
`define CPU_REG_IDX_W   3
`define CPU_IMM_W       16

`define CPU_RESET_PC    32'h0000_0000

// Opcodes in bits 31:28, unknown values behave as NOP
`define CPU_OP_NOP      4'h0
`define CPU_OP_ADD      4'h1
`define CPU_OP_SUB      4'h2
`define CPU_OP_AND      4'h3
`define CPU_OP_OR       4'h4
`define CPU_OP_XOR      4'h5
`define CPU_OP_MOVI     4'h6
`define CPU_OP_STORE    4'h7
`define CPU_OP_JMP      4'h8

`endif

//--- design/core_types_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package core_types_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;   // Register and store data
   typedef logic [`CPU_ADDR_W-1:0] addr_t;   // Byte address

endpackage

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

   typedef logic [31:0]               instr_t;
   typedef logic [3:0]                opcode_t;
   typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`CPU_IMM_W-1:0]     imm_t;

   typedef enum logic [1:0] {
      idle,
      wait_grant,   // imem_valid up
      wait_data     // Request accepted, response outstanding
   } fetch_state_t;

   // Two-operand ops, dest = dest op src
   function automatic logic op_is_alu(opcode_t op);
      return op inside {`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
   endfunction

   function automatic logic op_writes_reg(opcode_t op);
      return op_is_alu(op) || op == `CPU_OP_MOVI;
   endfunction

endpackage

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetch_unit import core_types_pkg::*, isa_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,

   input  logic   redirect,
   input  addr_t  redirect_pc,

   output logic   imem_valid,
   input  logic   imem_ready,
   output addr_t  imem_address,
   input  logic   imem_dp_valid,
   output logic   imem_dp_ready,
   input  instr_t imem_dp_read_data,

   output logic   f_valid,
   input  logic   f_ready,
   output instr_t f_instr,
   output addr_t  f_pc
);

   fetch_state_t state;
   addr_t        pc;         // Next address to request
   addr_t        req_addr;
   logic         discard;    // Outstanding response is stale
   logic         slot_valid;
   instr_t       slot_instr;
   addr_t        slot_pc;
   logic         slot_free;
   logic         issue;
   logic         rsp_take;
   logic         rsp_keep;

   assign imem_valid    = state == wait_grant;
   assign imem_address  = req_addr;
   assign imem_dp_ready = state == wait_data;

   assign slot_free = !slot_valid || f_ready;
   assign issue     = state == idle && slot_free && !redirect;
   assign rsp_take  = imem_dp_valid && state == wait_data;
   assign rsp_keep  = rsp_take && !discard && !redirect;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= idle;
         pc         <= `CPU_RESET_PC;
         discard    <= 1'b0;
         slot_valid <= 1'b0;
      end else begin
         case (state)
            idle:       if (issue) state <= wait_grant;
            wait_grant: if (imem_ready) state <= wait_data;
            wait_data:  if (rsp_take) state <= idle;
            default:    state <= idle;
         endcase

         if (redirect)
            pc <= redirect_pc;
         else if (issue)
            pc <= pc + 32'd4;

         // A request already on the bus still has to finish
         if (redirect && state != idle && !rsp_take)
            discard <= 1'b1;
         else if (rsp_take)
            discard <= 1'b0;

         if (redirect)
            slot_valid <= 1'b0;
         else if (rsp_keep)
            slot_valid <= 1'b1;
         else if (f_ready)
            slot_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue)
         req_addr <= pc;
      if (rsp_keep) begin
         slot_instr <= imem_dp_read_data;
         slot_pc    <= req_addr;
      end
   end

   assign f_valid = slot_valid;
   assign f_instr = slot_instr;
   assign f_pc    = slot_pc;

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

// eax, ecx, edx, ebx, esp, ebp, esi, edi
module register_file import core_types_pkg::*, isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   input  reg_idx_t rd_idx_a,
   input  reg_idx_t rd_idx_b,
   output word_t    rd_data_a,
   output word_t    rd_data_b,

   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data
);

   word_t regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

//--- design/decode_regread.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode_regread import core_types_pkg::*, isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     redirect,

   input  logic     f_valid,
   output logic     f_ready,
   input  instr_t   f_instr,

   output reg_idx_t rd_idx_a,
   output reg_idx_t rd_idx_b,
   input  word_t    rd_data_a,
   input  word_t    rd_data_b,

   input  logic     ex_pending,
   input  reg_idx_t ex_dest,

   output logic     d_valid,
   input  logic     d_ready,
   output opcode_t  d_op,
   output reg_idx_t d_dest,
   output word_t    d_a,
   output word_t    d_b,
   output imm_t     d_imm
);

   opcode_t  f_op;
   reg_idx_t f_dest;
   reg_idx_t f_src;
   imm_t     f_imm;
   logic     reads_a;
   logic     reads_b;
   logic     d_writes;
   logic     ex_hit;
   logic     d_hit;
   logic     hazard;
   logic     f_take;

   assign f_op   = f_instr[31:28];
   assign f_dest = f_instr[26:24];
   assign f_src  = f_instr[22:20];
   assign f_imm  = f_instr[15:0];

   assign rd_idx_a = f_dest;
   assign rd_idx_b = f_src;

   assign reads_a = op_is_alu(f_op);
   assign reads_b = op_is_alu(f_op) || f_op == `CPU_OP_STORE;

   // Producers ahead of us: the result register in execute and our own output
   assign d_writes = d_valid && op_writes_reg(d_op);

   assign ex_hit = ex_pending &&
                   ((reads_a && ex_dest == f_dest) || (reads_b && ex_dest == f_src));
   assign d_hit  = d_writes &&
                   ((reads_a && d_dest == f_dest) || (reads_b && d_dest == f_src));
   assign hazard = ex_hit || d_hit;

   assign f_ready = (!d_valid || d_ready) && !hazard;
   assign f_take  = f_valid && f_ready && !redirect;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         d_valid <= 1'b0;
      end else begin
         if (redirect)
            d_valid <= 1'b0;   // Younger than the jump
         else if (f_take)
            d_valid <= 1'b1;
         else if (d_ready)
            d_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (f_take) begin
         d_op   <= f_op;
         d_dest <= f_dest;
         d_a    <= rd_data_a;
         d_b    <= rd_data_b;
         d_imm  <= f_imm;
      end
   end

endmodule

`default_nettype wire

//--- design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module execute_unit import core_types_pkg::*, isa_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     d_valid,
   output logic     d_ready,
   input  opcode_t  d_op,
   input  reg_idx_t d_dest,
   input  word_t    d_a,
   input  word_t    d_b,
   input  imm_t     d_imm,

   output logic     wr_en,
   output reg_idx_t wr_idx,
   output word_t    wr_data,

   output logic     ex_pending,
   output reg_idx_t ex_dest,

   output logic     redirect,
   output addr_t    redirect_pc,

   output logic     wmem_valid,
   input  logic     wmem_ready,
   output addr_t    wmem_address,
   output word_t    wmem_wr_data
);

   logic     res_valid;
   opcode_t  res_op;
   logic     res_wr;
   reg_idx_t res_dest;
   word_t    res_data;
   addr_t    res_addr;
   logic     res_store;
   logic     res_jmp;
   logic     res_done;
   logic     d_take;
   word_t    alu_out;

   assign res_store = res_valid && res_op == `CPU_OP_STORE;
   assign res_jmp   = res_valid && res_op == `CPU_OP_JMP;
   assign res_done  = !res_store || wmem_ready;

   // Nothing enters behind a taken jump
   assign d_ready = !res_valid || (res_done && !res_jmp);
   assign d_take  = d_valid && d_ready;

   always_comb begin
      case (d_op)
         `CPU_OP_ADD:   alu_out = d_a + d_b;
         `CPU_OP_SUB:   alu_out = d_a - d_b;
         `CPU_OP_AND:   alu_out = d_a & d_b;
         `CPU_OP_OR:    alu_out = d_a | d_b;
         `CPU_OP_XOR:   alu_out = d_a ^ d_b;
         `CPU_OP_MOVI:  alu_out = word_t'(d_imm);
         `CPU_OP_STORE: alu_out = d_b;   // Store data from the source reg
         default:       alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else begin
         if (d_take)
            res_valid <= 1'b1;
         else if (res_done)
            res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (d_take) begin
         res_op   <= d_op;
         res_wr   <= op_writes_reg(d_op);
         res_dest <= d_dest;
         res_data <= alu_out;
         res_addr <= addr_t'(d_imm);   // Store address or jump target
      end
   end

   assign wr_en   = res_valid && res_wr;
   assign wr_idx  = res_dest;
   assign wr_data = res_data;

   assign ex_pending = res_valid && res_wr;
   assign ex_dest    = res_dest;

   assign redirect    = res_jmp;
   assign redirect_pc = res_addr;

   assign wmem_valid   = res_store;
   assign wmem_address = res_addr;
   assign wmem_wr_data = res_data;

endmodule

`default_nettype wire

//--- design/cpu_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline_top import core_types_pkg::*, isa_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,

   output logic   imem_valid,
   input  logic   imem_ready,
   output addr_t  imem_address,
   input  logic   imem_dp_valid,
   output logic   imem_dp_ready,
   input  instr_t imem_dp_read_data,

   output logic   wmem_valid,
   input  logic   wmem_ready,
   output addr_t  wmem_address,
   output word_t  wmem_wr_data
);

   // Fetch to decode
   logic     f_valid;
   logic     f_ready;
   instr_t   f_instr;

   // Register file ports
   reg_idx_t rd_idx_a;
   reg_idx_t rd_idx_b;
   word_t    rd_data_a;
   word_t    rd_data_b;
   logic     wr_en;
   reg_idx_t wr_idx;
   word_t    wr_data;

   // Decode to execute
   logic     d_valid;
   logic     d_ready;
   opcode_t  d_op;
   reg_idx_t d_dest;
   word_t    d_a;
   word_t    d_b;
   imm_t     d_imm;

   logic     ex_pending;
   reg_idx_t ex_dest;
   logic     redirect;
   addr_t    redirect_pc;

   fetch_unit i_fetch_unit (
      .clk               (clk),
      .rst_n             (rst_n),
      .redirect          (redirect),
      .redirect_pc       (redirect_pc),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .f_valid           (f_valid),
      .f_ready           (f_ready),
      .f_instr           (f_instr),
      .f_pc              ()
   );

   decode_regread i_decode_regread (
      .clk        (clk),
      .rst_n      (rst_n),
      .redirect   (redirect),
      .f_valid    (f_valid),
      .f_ready    (f_ready),
      .f_instr    (f_instr),
      .rd_idx_a   (rd_idx_a),
      .rd_idx_b   (rd_idx_b),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .ex_pending (ex_pending),
      .ex_dest    (ex_dest),
      .d_valid    (d_valid),
      .d_ready    (d_ready),
      .d_op       (d_op),
      .d_dest     (d_dest),
      .d_a        (d_a),
      .d_b        (d_b),
      .d_imm      (d_imm)
   );

   register_file i_register_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data)
   );

   execute_unit i_execute_unit (
      .clk          (clk),
      .rst_n        (rst_n),
      .d_valid      (d_valid),
      .d_ready      (d_ready),
      .d_op         (d_op),
      .d_dest       (d_dest),
      .d_a          (d_a),
      .d_b          (d_b),
      .d_imm        (d_imm),
      .wr_en        (wr_en),
      .wr_idx       (wr_idx),
      .wr_data      (wr_data),
      .ex_pending   (ex_pending),
      .ex_dest      (ex_dest),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data)
   );

endmodule

`default_nettype wire

//--- tb/tb_cpu_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_pipeline import core_types_pkg::*, isa_pkg::*; ();

   localparam int MEM_DEPTH   = 64;
   localparam int CYCLE_LIMIT = 4000;
   localparam int HALT_HITS   = 3;   // Fetches of the halt word before a run is over

   logic   clk;
   logic   rst_n;
   logic   imem_valid;
   logic   imem_ready;
   addr_t  imem_address;
   logic   imem_dp_valid;
   logic   imem_dp_ready;
   instr_t imem_dp_read_data;
   logic   wmem_valid;
   logic   wmem_ready;
   addr_t  wmem_address;
   word_t  wmem_wr_data;

   integer seed = 32'h5bb5_27c7;
   instr_t imem [MEM_DEPTH];
   int     prog_len;
   addr_t  halt_addr;
   logic   bp_en;
   logic   req_pend;
   addr_t  req_addr;
   int     req_wait;
   int     halt_hits;
   logic   first_seen;
   addr_t  first_addr;
   logic   wmem_seen;
   addr_t  st_addr [$];
   word_t  st_data [$];
   addr_t  exp_addr [$];
   word_t  exp_data [$];
   int     cycles;
   int     errors;
   int     tests;

   cpu_pipeline_top i_cpu_pipeline_top (
      .clk               (clk),
      .rst_n             (rst_n),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .wmem_valid        (wmem_valid),
      .wmem_ready        (wmem_ready),
      .wmem_address      (wmem_address),
      .wmem_wr_data      (wmem_wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Instruction memory handshake and store monitor
   always @(posedge clk) begin
      if (!rst_n) begin
         req_pend   <= 1'b0;
         req_wait   <= 0;
         halt_hits  <= 0;
         first_seen <= 1'b0;
         wmem_seen  <= 1'b0;
      end else begin
         if (imem_valid && imem_ready) begin
            req_pend <= 1'b1;
            req_addr <= imem_address;
            req_wait <= $random(seed) & 3;   // 0 to 3 cycles
            if (!first_seen) begin
               first_seen <= 1'b1;
               first_addr <= imem_address;
            end
            if (imem_address == halt_addr)
               halt_hits <= halt_hits + 1;
         end else if (imem_dp_valid && imem_dp_ready) begin
            req_pend <= 1'b0;
         end else if (req_wait > 0) begin
            req_wait <= req_wait - 1;
         end
         if (wmem_valid)
            wmem_seen <= 1'b1;
         if (wmem_valid && wmem_ready) begin
            st_addr.push_back(wmem_address);
            st_data.push_back(wmem_wr_data);
         end
      end
   end

   always @(negedge clk) begin
      // Ready only while one request is outstanding
      if (rst_n && imem_dp_ready !== req_pend) begin
         $display("imem_dp_ready does not follow the outstanding request");
         errors++;
      end
      imem_dp_valid     <= req_pend && req_wait == 0;
      imem_dp_read_data <= imem[req_addr[7:2]];
      wmem_ready        <= bp_en ? ($random(seed) % 2 == 0) : 1'b1;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the program never reached its halt, fetch state %s",
               cycles, i_cpu_pipeline_top.i_fetch_unit.state.name());
      $display("TEST RESULT: FAIL");
      $finish;
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic new_program();
      for (int i = 0; i < MEM_DEPTH; i++)
         imem[i] = {`CPU_OP_JMP, 12'h000, 16'(i * 4)};   // Each word jumps to itself
      prog_len = 0;
   endtask

   task automatic emit(input opcode_t op, input reg_idx_t dest, input reg_idx_t src,
                       input imm_t imm);
      imem[prog_len] = {op, 1'b0, dest, 1'b0, src, 4'h0, imm};
      prog_len++;
   endtask

   task automatic emit_halt();
      halt_addr = addr_t'(prog_len * 4);
      emit(`CPU_OP_JMP, 0, 0, imm_t'(prog_len * 4));
   endtask

   // Plain interpreter of the ISA, collects the expected stores
   task automatic run_model();
      word_t    regs [`CPU_NUM_REGS];
      addr_t    pc;
      instr_t   ins;
      reg_idx_t d;
      word_t    a;
      word_t    b;
      int       steps;
      for (int i = 0; i < `CPU_NUM_REGS; i++)
         regs[i] = '0;
      exp_addr.delete();
      exp_data.delete();
      pc    = `CPU_RESET_PC;
      steps = 0;
      while (steps < 1000) begin
         ins = imem[pc[7:2]];
         if (ins[31:28] == `CPU_OP_JMP && addr_t'(ins[15:0]) == pc)
            break;
         d  = ins[26:24];
         a  = regs[d];
         b  = regs[ins[22:20]];
         pc = pc + 32'd4;
         case (ins[31:28])
            `CPU_OP_ADD:  regs[d] = a + b;
            `CPU_OP_SUB:  regs[d] = a - b;
            `CPU_OP_AND:  regs[d] = a & b;
            `CPU_OP_OR:   regs[d] = a | b;
            `CPU_OP_XOR:  regs[d] = a ^ b;
            `CPU_OP_MOVI: regs[d] = word_t'(ins[15:0]);
            `CPU_OP_STORE: begin
               exp_addr.push_back(addr_t'(ins[15:0]));
               exp_data.push_back(b);
            end
            `CPU_OP_JMP:  pc = addr_t'(ins[15:0]);
            default:      ;
         endcase
         steps++;
      end
   endtask

   task automatic reset_dut();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (4) @(negedge clk);
      st_addr.delete();
      st_data.delete();
      rst_n = 1'b1;
   endtask

   task automatic run_program(input logic bp);
      bp_en = bp;
      run_model();
      reset_dut();
      while (halt_hits < HALT_HITS)
         @(posedge clk);
      repeat (8) @(posedge clk);   // Drain
      check_addr("imem_address", `CPU_RESET_PC, first_addr);
      if (st_addr.size() != exp_addr.size()) begin
         $display("Wrong number of stores, expected %0d but saw %0d",
                  exp_addr.size(), st_addr.size());
         errors++;
      end else begin
         for (int i = 0; i < st_addr.size(); i++) begin
            check_addr("wmem_address", exp_addr[i], st_addr[i]);
            check_word("wmem_wr_data", exp_data[i], st_data[i]);
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests++;
      $display("%-16s %0d stores, %0d errors", name, st_addr.size(), errors - err_start);
   endtask

   task automatic test_reset_state();
      int err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 2, 0, 16'h0042);
      emit_halt();
      run_program(1'b0);
      if (wmem_seen) begin
         $display("wmem_valid went high in a program without stores");
         errors++;
      end
      finish_test("reset_state", err_start);
   endtask

   task automatic test_arith();
      opcode_t ops [5] = '{`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
      int      err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 0, 0, 16'h1234);
      emit(`CPU_OP_MOVI, 1, 0, 16'h0ff0);
      for (int k = 0; k < 5; k++) begin
         emit(`CPU_OP_MOVI, k + 2, 0, 16'h1234);
         emit(ops[k], k + 2, 1, 16'h0);
         emit(`CPU_OP_STORE, 0, k + 2, imm_t'(16'h0100 + 4 * k));
      end
      emit(`CPU_OP_MOVI, 7, 0, 16'h0001);
      emit(`CPU_OP_SUB, 7, 0, 16'h0);    // Wraps below zero
      emit(`CPU_OP_STORE, 0, 7, 16'h0114);
      emit(`CPU_OP_STORE, 0, 1, 16'h0118);
      emit_halt();
      run_program(1'b0);
      finish_test("arith", err_start);
   endtask

   task automatic test_dependent();
      int err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 0, 0, 16'h0005);
      emit(`CPU_OP_ADD, 0, 0, 16'h0);
      emit(`CPU_OP_ADD, 0, 0, 16'h0);
      emit(`CPU_OP_STORE, 0, 0, 16'h0200);
      emit(`CPU_OP_XOR, 1, 0, 16'h0);
      emit(`CPU_OP_SUB, 1, 0, 16'h0);
      emit(`CPU_OP_STORE, 0, 1, 16'h0204);
      emit(`CPU_OP_OR, 2, 1, 16'h0);
      emit(`CPU_OP_AND, 2, 0, 16'h0);
      emit(`CPU_OP_STORE, 0, 2, 16'h0208);
      emit(`CPU_OP_MOVI, 3, 0, 16'hffff);
      emit(`CPU_OP_ADD, 3, 3, 16'h0);
      emit(`CPU_OP_STORE, 0, 3, 16'h020c);
      emit_halt();
      run_program(1'b0);
      finish_test("dependent", err_start);
   endtask

   task automatic test_jump();
      int err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 0, 0, 16'h00aa);
      emit(`CPU_OP_STORE, 0, 0, 16'h0300);
      emit(`CPU_OP_JMP, 0, 0, imm_t'((prog_len + 3) * 4));   // Over two stores
      emit(`CPU_OP_STORE, 0, 0, 16'h0304);
      emit(`CPU_OP_STORE, 0, 0, 16'h0308);
      emit(`CPU_OP_MOVI, 1, 0, 16'h0055);
      emit(`CPU_OP_STORE, 0, 1, 16'h030c);
      emit(`CPU_OP_JMP, 0, 0, imm_t'((prog_len + 2) * 4));
      emit(`CPU_OP_MOVI, 1, 0, 16'h0bad);
      emit(`CPU_OP_STORE, 0, 1, 16'h0310);
      emit_halt();
      run_program(1'b0);
      finish_test("jump", err_start);
   endtask

   task automatic test_backpressure();
      int err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 0, 0, 16'h0001);
      for (int k = 0; k < 8; k++) begin
         emit(`CPU_OP_STORE, 0, 0, imm_t'(16'h0400 + 4 * k));
         emit(`CPU_OP_ADD, 0, 0, 16'h0);
      end
      emit(`CPU_OP_STORE, 0, 0, 16'h0440);   // Back to back stores
      emit(`CPU_OP_STORE, 0, 0, 16'h0444);
      emit(`CPU_OP_STORE, 0, 0, 16'h0448);
      emit_halt();
      run_program(1'b1);
      finish_test("backpressure", err_start);
   endtask

   task automatic test_mixed();
      int err_start;
      err_start = errors;
      new_program();
      emit(`CPU_OP_MOVI, 4, 0, 16'h0f0f);
      emit(`CPU_OP_MOVI, 5, 0, 16'h3c3c);
      emit(`CPU_OP_XOR, 4, 5, 16'h0);
      emit(`CPU_OP_STORE, 0, 4, 16'h0500);
      emit(`CPU_OP_JMP, 0, 0, imm_t'((prog_len + 3) * 4));
      emit(`CPU_OP_STORE, 0, 4, 16'h05f0);
      emit(`CPU_OP_MOVI, 4, 0, 16'h0000);
      emit(`CPU_OP_AND, 5, 4, 16'h0);
      emit(`CPU_OP_STORE, 0, 5, 16'h0504);
      emit(`CPU_OP_OR, 6, 5, 16'h0);
      emit(`CPU_OP_SUB, 6, 4, 16'h0);
      emit(`CPU_OP_STORE, 0, 6, 16'h0508);
      emit(`CPU_OP_JMP, 0, 0, imm_t'((prog_len + 2) * 4));   // Straight to the halt
      emit(`CPU_OP_STORE, 0, 6, 16'h050c);
      emit_halt();
      run_program(1'b1);
      finish_test("mixed", err_start);
   endtask

   initial begin
      rst_n             = 1'b0;
      imem_ready        = 1'b1;
      imem_dp_valid     = 1'b0;
      imem_dp_read_data = '0;
      wmem_ready        = 1'b1;
      bp_en             = 1'b0;
      req_addr          = '0;
      halt_addr         = '0;
      errors            = 0;
      tests             = 0;
      new_program();

      test_reset_state();
      test_arith();
      test_dependent();
      test_jump();
      test_backpressure();
      test_mixed();

      $display("%0d tests run, %0d errors, %0d cycles", tests, errors, cycles);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/core_types_pkg.sv
design/isa_pkg.sv
design/fetch_unit.sv
design/register_file.sv
design/decode_regread.sv
design/execute_unit.sv
design/cpu_pipeline_top.sv
tb/tb_cpu_pipeline.sv

//--- Bender.yml
package:
  name: cpu_pipeline

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/core_types_pkg.sv
      - design/isa_pkg.sv
      - design/fetch_unit.sv
      - design/register_file.sv
      - design/decode_regread.sv
      - design/execute_unit.sv
      - design/cpu_pipeline_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_cpu_pipeline.sv
